// ==== common/burstBufPkg.sv ====
// shared sizes, sequencer states and width helper for the burst buffer
// imported by wildcard in each module header that needs it
`default_nettype none

package burstBufPkg;

	// ------------------------------------------------------------------------
	// width helper
	// ------------------------------------------------------------------------
	// bits needed to hold count distinct values, at least one
	function automatic int fBitWidth(input int count);
		int bits;
		bits = 1;
		while ((1 << bits) < count)
		begin
			bits++;
		end
		return bits;
	endfunction

	// ------------------------------------------------------------------------
	// buffer geometry
	// ------------------------------------------------------------------------
	// ram slots, one stays unused so full and empty differ
	localparam int FifoDepth   = 16;
	localparam int DataWidth   = 8;
	localparam int AddrWidth   = fBitWidth(FifoDepth);
	// stored count that raises the level alert
	localparam int AlertBorder = 8;

	// burst and flush timing
	localparam int BurstLen  = 8;
	localparam int IdleLimit = 32;
	// beat count runs 0 .. BurstLen-1
	localparam int BeatWidth = fBitWidth(BurstLen);
	// idle count must reach IdleLimit itself
	localparam int IdleWidth = fBitWidth(IdleLimit + 1);

	// read side FSM states
	typedef enum logic [1:0] {
		IDLE,
		BURST,
		FLUSH
	} seqState_t;

endpackage

`default_nettype wire

// ==== common/fifoReadIf.sv ====
// read port of the FIFO as seen by the burst sequencer
// fifo modport on the controller side, seq modport on the sequencer side
`timescale 1ns/1ps
`default_nettype none

interface fifoReadIf
	import burstBufPkg::*;
();

	// registered ram output, valid while rvd is high
	logic [DataWidth-1:0] rd;
	// read request, taken only when emp is low
	logic re;
	// one cycle after an accepted read
	logic rvd;
	logic emp;
	// stored count at or above the border
	logic alert;

	modport fifo (
		output rd,
		output rvd,
		output emp,
		output alert,
		input  re
	);

	modport seq (
		output re,
		input  rd,
		input  rvd,
		input  emp,
		input  alert
	);

endinterface

`default_nettype wire

// ==== syncFifo/sdpBram.sv ====
// simple dual port block RAM, one write port and one registered read port
// read register holds its word until the next enabled read
`timescale 1ns/1ps
`default_nettype none

module sdpBram
	import burstBufPkg::*;
(
	input  logic                 iCLK,
	input  logic [DataWidth-1:0] iWd,
	input  logic [AddrWidth-1:0] iWa,
	input  logic                 iWe,
	input  logic [AddrWidth-1:0] iRa,
	input  logic                 iRe,
	output logic [DataWidth-1:0] oRd
);

	// storage array, no reset like the real block
	logic [DataWidth-1:0] mem [FifoDepth];

	// ------------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iWe)
		begin
			mem[iWa] <= iWd;
		end
	end

	// ------------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------------
	// registered output, loads only when enabled
	// a word written at the same edge is not read here
	// controller never reads an empty slot
	always_ff @(posedge iCLK)
	begin
		if (iRe)
		begin
			oRd <= mem[iRa];
		end
	end

endmodule

`default_nettype wire

// ==== syncFifo/syncFifoController.sv ====
// single clock FIFO controller with a fill level alert
// write side on plain ports, read side on fifoReadIf, storage in sdpBram
`timescale 1ns/1ps
`default_nettype none

module syncFifoController
	import burstBufPkg::*;
(
	input  logic                 iCLK,
	input  logic                 inARST,
	input  logic [DataWidth-1:0] iWd,
	input  logic                 iWe,
	output logic                 oFull,
	fifoReadIf.fifo              rdPort
);

	// ------------------------------------------------------------------------
	// pointers and accepted strobes
	// ------------------------------------------------------------------------
	// write pointer, next free slot
	logic [AddrWidth-1:0] wa;
	// read pointer, oldest stored word
	logic [AddrWidth-1:0] ra;
	// write pointer one step ahead, used for full
	logic [AddrWidth-1:0] waNext;
	// stored count, wraps with the pointers
	logic [AddrWidth-1:0] fill;
	// accepted write and read this cycle
	logic wrOk;
	logic rdOk;
	logic emp;

	assign waNext = wa + 1'b1;
	assign fill   = wa - ra;

	// flags straight from the pointers
	// full leaves one slot empty
	assign oFull = (waNext == ra);
	assign emp   = (wa == ra);

	// drop writes while full, ignore reads while empty
	assign wrOk = iWe & ~oFull;
	assign rdOk = rdPort.re & ~emp;

	// ------------------------------------------------------------------------
	// pointer update
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wa <= '0;
		end
		else if (wrOk)
		begin
			// wraps at FifoDepth by width
			wa <= waNext;
		end
	end

	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			ra <= '0;
		end
		else if (rdOk)
		begin
			ra <= ra + 1'b1;
		end
	end

	// read data valid, one cycle behind the accepted read
	// matches the registered ram output
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rdPort.rvd <= 1'b0;
		end
		else
		begin
			rdPort.rvd <= rdOk;
		end
	end

	// ------------------------------------------------------------------------
	// read side flags
	// ------------------------------------------------------------------------
	assign rdPort.emp = emp;

	// level alert for long latency readers
	assign rdPort.alert = (fill >= AddrWidth'(AlertBorder));

	// ------------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------------
	// full width in one ram, read register loads on accepted reads only
	sdpBram bram (
		.iCLK (iCLK),
		.iWd  (iWd),
		.iWa  (wa),
		.iWe  (wrOk),
		.iRa  (ra),
		.iRe  (rdOk),
		.oRd  (rdPort.rd)
	);

endmodule

`default_nettype wire

// ==== logic/beatCounter.sv ====
// beat count within a burst and idle timer for the burst sequencer
// plain strobes in, burst end and idle expiry out
`timescale 1ns/1ps
`default_nettype none

module beatCounter
	import burstBufPkg::*;
(
	input  logic iCLK,
	input  logic inARST,
	input  logic beatClr,
	input  logic beatInc,
	input  logic idleRun,
	output logic beatDone,
	output logic idleExpired
);

	logic [BeatWidth-1:0] beatCnt;
	logic [IdleWidth-1:0] idleCnt;

	// ------------------------------------------------------------------------
	// beats
	// ------------------------------------------------------------------------
	// clear wins over a step
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			beatCnt <= '0;
		end
		else if (beatClr)
		begin
			beatCnt <= '0;
		end
		else if (beatInc)
		begin
			beatCnt <= beatCnt + 1'b1;
		end
	end

	// last read of the burst is being made
	assign beatDone = beatInc & (beatCnt == BeatWidth'(BurstLen - 1));

	// ------------------------------------------------------------------------
	// idle timer
	// ------------------------------------------------------------------------
	// restarts whenever idleRun drops, holds at the limit
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			idleCnt <= '0;
		end
		else if (!idleRun)
		begin
			idleCnt <= '0;
		end
		else if (!idleExpired)
		begin
			idleCnt <= idleCnt + 1'b1;
		end
	end

	assign idleExpired = (idleCnt == IdleWidth'(IdleLimit));

endmodule

`default_nettype wire

// ==== logic/burstSequencer.sv ====
// read side FSM, waits for the FIFO alert and drains fixed length bursts
// flushes leftover words after the idle timer runs out
`timescale 1ns/1ps
`default_nettype none

module burstSequencer
	import burstBufPkg::*;
(
	input  logic    iCLK,
	input  logic    inARST,
	input  logic    iStall,
	fifoReadIf.seq  rdPort,
	output logic    beatClr,
	output logic    beatInc,
	output logic    idleRun,
	input  logic    beatDone,
	input  logic    idleExpired,
	output logic    oBurstLast
);

	seqState_t state;
	seqState_t stateNext;
	// read made this cycle
	logic readNow;
	// last beat of a burst is in flight
	logic burstLastQ;
	// a flush read is in flight
	logic flushRdQ;

	// ------------------------------------------------------------------------
	// read request
	// ------------------------------------------------------------------------
	// no new reads while stalled, in flight word still shows up
	// emp gate keeps re low on an empty FIFO
	assign readNow   = (state != IDLE) & ~iStall & ~rdPort.emp;
	assign rdPort.re = readNow;

	// beat and idle counter control
	assign beatInc = readNow & (state == BURST);
	// clear on the way out of IDLE
	assign beatClr = (state == IDLE) & (rdPort.alert | idleExpired);
	// idle timer only counts while words wait
	assign idleRun = (state == IDLE) & ~rdPort.emp;

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
			begin
				// alert wins over a flush
				if (rdPort.alert)
				begin
					stateNext = BURST;
				end
				else if (idleExpired)
				begin
					stateNext = FLUSH;
				end
			end
			BURST:
			begin
				if (beatDone)
				begin
					stateNext = IDLE;
				end
			end
			FLUSH:
			begin
				// drained, new writes start over in IDLE
				if (rdPort.emp)
				begin
					stateNext = IDLE;
				end
			end
			default:
			begin
				stateNext = IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// state and last pending flags
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			state      <= IDLE;
			burstLastQ <= 1'b0;
			flushRdQ   <= 1'b0;
		end
		else
		begin
			state      <= stateNext;
			// beatDone already includes the read
			burstLastQ <= beatDone;
			flushRdQ   <= readNow & (state == FLUSH);
		end
	end

	// last marker lines up with rvd
	// a flush word is last when its read left the FIFO empty
	assign oBurstLast = burstLastQ | (flushRdQ & rdPort.emp);

endmodule

`default_nettype wire

// ==== logic/burstBufferTop.sv ====
// top of the burst buffer, word FIFO in front of a burst consumer
// plain write ports in, burst data with valid and last out
`timescale 1ns/1ps
`default_nettype none

module burstBufferTop
	import burstBufPkg::*;
(
	input  logic                 iCLK,
	input  logic                 inARST,
	input  logic [DataWidth-1:0] iWd,
	input  logic                 iWe,
	output logic                 oFull,
	input  logic                 iStall,
	output logic [DataWidth-1:0] oBurstData,
	output logic                 oBurstValid,
	output logic                 oBurstLast
);

	// ------------------------------------------------------------------------
	// internal links
	// ------------------------------------------------------------------------
	// FIFO read port, controller to sequencer
	fifoReadIf rdIf ();

	// sequencer to beat counter
	logic beatClr;
	logic beatInc;
	logic idleRun;
	logic beatDone;
	logic idleExpired;

	// ------------------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------------------
	syncFifoController fifoCtrl (
		.iCLK   (iCLK),
		.inARST (inARST),
		.iWd    (iWd),
		.iWe    (iWe),
		.oFull  (oFull),
		.rdPort (rdIf.fifo)
	);

	burstSequencer seq (
		.iCLK        (iCLK),
		.inARST      (inARST),
		.iStall      (iStall),
		.rdPort      (rdIf.seq),
		.beatClr     (beatClr),
		.beatInc     (beatInc),
		.idleRun     (idleRun),
		.beatDone    (beatDone),
		.idleExpired (idleExpired),
		.oBurstLast  (oBurstLast)
	);

	beatCounter beats (
		.iCLK        (iCLK),
		.inARST      (inARST),
		.beatClr     (beatClr),
		.beatInc     (beatInc),
		.idleRun     (idleRun),
		.beatDone    (beatDone),
		.idleExpired (idleExpired)
	);

	// output words come straight from the ram read register
	assign oBurstData  = rdIf.rd;
	assign oBurstValid = rdIf.rvd;

endmodule

`default_nettype wire

// ==== testbench/burstBufferChecker.sv ====
// watches the burst buffer ports and keeps a model of the stored words
// compares every output word, the full flag and each burst length
`timescale 1ns/1ps
`default_nettype none

module burstBufferChecker
	import burstBufPkg::*;
(
	input  logic                 iCLK,
	input  logic                 inARST,
	input  logic [DataWidth-1:0] iWd,
	input  logic                 iWe,
	input  logic                 oFull,
	input  logic [DataWidth-1:0] oBurstData,
	input  logic                 oBurstValid,
	input  logic                 oBurstLast,
	output int                   errCount,
	output int                   pendingBursts
);

	// accepted words not yet seen at the output
	logic [DataWidth-1:0] model [$];
	// expected burst and flush lengths, oldest first
	int expLens [$];
	int sinceLast;
	int wordCount;
	int burstCount;
	int resetEdges;
	logic [DataWidth-1:0] expWord;

	initial
	begin
		errCount      = 0;
		pendingBursts = 0;
		sinceLast     = 0;
		wordCount     = 0;
		burstCount    = 0;
		resetEdges    = 0;
	end

	// ------------------------------------------------------------------------
	// helpers, also called from the testbench top
	// ------------------------------------------------------------------------
	task automatic noteFailure(input string msg);
		errCount++;
		$display("%0t ns: %s", $time, msg);
	endtask

	task automatic checkBit(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			errCount++;
			$display("ERR %0t %s exp %0b got %0b", $time, name, exp, act);
		end
	endtask

	task automatic expectBurst(input int len);
		expLens.push_back(len);
		pendingBursts = expLens.size();
	endtask

	// words accepted but not yet delivered
	task automatic checkBuffered(input int count);
		if (model.size() != count)
		begin
			errCount++;
			$display("ERR %0t buffered words exp %0d got %0d", $time, count, model.size());
		end
	endtask

	task automatic checkBurstEnd();
		int expLen;
		if (!oBurstValid)
		begin
			noteFailure("burst end marker came without a valid word");
		end
		else if (expLens.size() == 0)
		begin
			noteFailure("burst ended but no further burst was expected");
		end
		else
		begin
			expLen = expLens.pop_front();
			if (sinceLast != expLen)
			begin
				errCount++;
				$display("ERR %0t oBurstLast burst words exp %0d got %0d",
					$time, expLen, sinceLast);
			end
		end
		sinceLast = 0;
		burstCount++;
	endtask

	task automatic printSummary(input int assertFails);
		$display("words %0d, bursts %0d, check errors %0d, assertion failures %0d",
			wordCount, burstCount, errCount, assertFails);
	endtask

	// ------------------------------------------------------------------------
	// per edge compare, pre edge values
	// ------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		if (!inARST)
		begin
			// outputs settle after the first reset edge
			if (resetEdges > 0)
			begin
				checkBit("oBurstValid", oBurstValid, 1'b0);
				checkBit("oBurstLast", oBurstLast, 1'b0);
				checkBit("oFull", oFull, 1'b0);
			end
			resetEdges++;
		end
		else
		begin
			if (oBurstValid)
			begin
				sinceLast++;
				wordCount++;
				if (model.size() == 0)
				begin
					noteFailure("output word with no accepted write left to match");
				end
				else
				begin
					expWord = model.pop_front();
					if (oBurstData !== expWord)
					begin
						errCount++;
						$display("ERR %0t oBurstData exp %02h got %02h",
							$time, expWord, oBurstData);
					end
				end
			end
			if (oBurstLast)
			begin
				checkBurstEnd();
			end
			// model now holds the stored count, one slot stays free
			checkBit("oFull", oFull, model.size() == FifoDepth - 1);
			if (iWe && model.size() < FifoDepth - 1)
			begin
				model.push_back(iWd);
			end
			pendingBursts = expLens.size();
		end
	end

endmodule

`default_nettype wire

// ==== testbench/burstBufferTb_asserts.sv ====
// concurrent checks on the FIFO controller and the burst sequencer
// bound once into each of the two blocks
`timescale 1ns/1ps
`default_nettype none

module burstBufferTb_asserts (
	input logic iCLK,
	input logic inARST,
	input logic re,
	input logic emp,
	input logic full,
	input logic rdAccept,
	input logic rvd,
	input logic stateOk
);

	// failed checks summed by the testbench top
	int failCount = 0;

	// no read request on an empty FIFO
	noReadOnEmpty: assert property (@(posedge iCLK) disable iff (!inARST) !(re && emp))
	else
	begin
		failCount++;
		$error("read requested while the FIFO is empty");
	end

	// a write taken while full wraps the pointers to empty
	// at most one read per edge so a full FIFO never shows empty next cycle
	noWriteOnFull: assert property (@(posedge iCLK) disable iff (!inARST) full |=> !emp)
	else
	begin
		failCount++;
		$error("write accepted while the FIFO is full");
	end

	// read data valid exactly one cycle after an accepted read
	validFollowsRead: assert property (@(posedge iCLK) disable iff (!inARST)
		rvd == $past(rdAccept))
	else
	begin
		failCount++;
		$error("read valid does not follow the accepted read");
	end

	// FSM only in its three states
	stateLegal: assert property (@(posedge iCLK) disable iff (!inARST) stateOk)
	else
	begin
		failCount++;
		$error("sequencer state outside its enum");
	end

endmodule

bind syncFifoController burstBufferTb_asserts fifoChecks (
	.iCLK     (iCLK),
	.inARST   (inARST),
	.re       (rdPort.re),
	.emp      (rdPort.emp),
	.full     (oFull),
	.rdAccept (rdOk),
	.rvd      (rdPort.rvd),
	.stateOk  (1'b1)
);

bind burstSequencer burstBufferTb_asserts seqChecks (
	.iCLK     (iCLK),
	.inARST   (inARST),
	.re       (rdPort.re),
	.emp      (rdPort.emp),
	.full     (1'b0),
	.rdAccept (rdPort.re & ~rdPort.emp),
	.rvd      (rdPort.rvd),
	.stateOk  ((state == IDLE) || (state == BURST) || (state == FLUSH))
);

`default_nettype wire

// ==== testbench/burstBufferTb.sv ====
// testbench top for the burst buffer, runs the commands of the stimulus file
// drives the DUT ports, the checker module compares the outputs
`timescale 1ns/1ps
`default_nettype none

module burstBufferTb
	import burstBufPkg::*;
();

	logic                 iCLK;
	logic                 inARST;
	logic [DataWidth-1:0] iWd;
	logic                 iWe;
	logic                 iStall;
	logic                 oFull;
	logic [DataWidth-1:0] oBurstData;
	logic                 oBurstValid;
	logic                 oBurstLast;
	int errCount;
	int pendingBursts;
	int assertFails;
	// stall for W and I, 0 low, 1 high, 2 random
	int stallMode;
	int fd;
	int code;
	int argA;
	int argB;
	logic [7:0] cmd;
	logic readOk;

	burstBufferTop UUT (
		.iCLK        (iCLK),
		.inARST      (inARST),
		.iWd         (iWd),
		.iWe         (iWe),
		.oFull       (oFull),
		.iStall      (iStall),
		.oBurstData  (oBurstData),
		.oBurstValid (oBurstValid),
		.oBurstLast  (oBurstLast)
	);

	burstBufferChecker chk (
		.iCLK          (iCLK),
		.inARST        (inARST),
		.iWd           (iWd),
		.iWe           (iWe),
		.oFull         (oFull),
		.oBurstData    (oBurstData),
		.oBurstValid   (oBurstValid),
		.oBurstLast    (oBurstLast),
		.errCount      (errCount),
		.pendingBursts (pendingBursts)
	);

	// 20 ns clock
	always #10 iCLK = ~iCLK;

	// ------------------------------------------------------------------------
	// drive helpers
	// ------------------------------------------------------------------------
	// one clock of inputs, set on the rising edge
	task automatic driveCycle(input logic we, input logic [DataWidth-1:0] wd, input int mode);
		@(posedge iCLK);
		iWe    <= we;
		iWd    <= wd;
		iStall <= (mode == 2) ? (($urandom % 2) != 0) : (mode == 1);
	endtask

	// rest of a comment line
	task automatic skipLine();
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
		begin
			c = $fgetc(fd);
		end
	endtask

	// idle cycles until all expected bursts came out, bounded
	task automatic waitBurstsDone();
		int waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		while (!done && waited < 400)
		begin
			@(negedge iCLK);
			if (pendingBursts == 0)
			begin
				done = 1'b1;
			end
			else
			begin
				driveCycle(1'b0, '0, stallMode);
				waited++;
			end
		end
		if (!done)
		begin
			chk.noteFailure("timed out waiting for the expected bursts to finish");
		end
	endtask

	task automatic runCommand();
		int i;
		if (cmd == "#")
		begin
			skipLine();
		end
		else if (cmd == "W")
		begin
			code = $fscanf(fd, "%d %d", argA, argB);
			for (i = 0; i < argB; i++)
			begin
				driveCycle(1'b1, DataWidth'(argA + i), stallMode);
			end
		end
		else
		begin
			code = $fscanf(fd, "%d", argA);
			case (cmd)
				"S": repeat (argA) driveCycle(1'b0, '0, 2);
				"I": repeat (argA) driveCycle(1'b0, '0, stallMode);
				"H": stallMode = argA;
				"B": chk.expectBurst(argA);
				"E":
				begin
					waitBurstsDone();
					chk.checkBuffered(argA);
				end
				default:
				begin
					chk.noteFailure("unknown command in the stimulus file");
					readOk = 1'b0;
				end
			endcase
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		void'($urandom(32'h93a5));
		iCLK      = 1'b0;
		inARST    = 1'b0;
		iWe       = 1'b0;
		iWd       = '0;
		iStall    = 1'b0;
		stallMode = 0;
		readOk    = 1'b1;
		// reset low for four clocks
		repeat (4) @(posedge iCLK);
		inARST <= 1'b1;
		fd = $fopen("testbench/burstStimulus.txt", "r");
		if (fd == 0)
		begin
			chk.noteFailure("the stimulus file could not be opened");
			readOk = 1'b0;
		end
		while (readOk)
		begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
			begin
				readOk = 1'b0;
			end
			else
			begin
				runCommand();
			end
		end
		if (fd != 0)
		begin
			$fclose(fd);
		end
		@(negedge iCLK);
		assertFails = UUT.fifoCtrl.fifoChecks.failCount + UUT.seq.seqChecks.failCount;
		chk.printSummary(assertFails);
		if (errCount + assertFails == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/burstStimulus.txt ====
# one command per line, decimal values, W data count | S cycles | I cycles
# H stall 0 low 1 high 2 random | B expected burst words | E words left at the end
I 3
# short group drained by the idle flush
B 5
H 0
W 1 5
I 60
# three full bursts without stall
B 8
B 8
B 8
W 32 24
I 20
# random stall on the read side
B 8
B 4
H 2
W 64 12
H 0
S 100
I 10
# output held back until the FIFO is full, last five writes dropped
B 8
B 7
H 1
W 96 20
H 0
I 80
# a few words left behind
W 128 3
I 5
E 3

// ==== flist.f ====
common/burstBufPkg.sv
common/fifoReadIf.sv
syncFifo/sdpBram.sv
syncFifo/syncFifoController.sv
logic/beatCounter.sv
logic/burstSequencer.sv
logic/burstBufferTop.sv
testbench/burstBufferChecker.sv
testbench/burstBufferTb_asserts.sv
testbench/burstBufferTb.sv
